// ==== rtl/SaturnBusPkg.sv ====
package SaturnBusPkg;

	// Main CPU bus
	localparam int CpuAddrWidth = 25;
	localparam int CpuDataWidth = 32;
	localparam int ByteLanes = 4;

	// Slow B-bus shared by the video and sound chips
	localparam int BBusDataWidth = 16;

	// Debug monitor
	localparam int WaitCntWidth = 8;

	// Boot code location watched by the hook flag
	localparam logic [CpuAddrWidth-1:0] HookAddr = 25'h0012B0;

	// Where main-bus read data comes from
	typedef enum logic [1:0] {
		ExtMemory,
		SystemManager,
		BusController
	} readSource_t;

endpackage

// ==== rtl/SaturnClockPkg.sv ====
package SaturnClockPkg;

	// Rising enables per slow peripheral enable
	localparam int SlowDivide = 7;
	localparam int SlowCntWidth = 3;

	// Break latch states
	typedef enum logic [1:0] {
		Unarmed,
		Running,
		Halted
	} debugState_t;

endpackage

// ==== rtl/CpuBusIf.sv ====
`timescale 1ns/10ps

interface CpuBusIf import SaturnBusPkg::*; ();

	logic [CpuAddrWidth-1:0] Addr;
	logic RdN;
	logic [ByteLanes-1:0] DqmN;
	logic Cs3N;

	modport source (
		output Addr,
		output RdN,
		output DqmN,
		output Cs3N
	);

	modport observer (
		input Addr,
		input RdN,
		input DqmN,
		input Cs3N
	);

endinterface

// ==== rtl/ClockEnIf.sv ====
`timescale 1ns/10ps

interface ClockEnIf ();

	logic CeR;
	logic CeF;
	logic SmpcCe;
	logic MasterRstN;

	modport generator (
		output CeR,
		output CeF,
		output SmpcCe,
		output MasterRstN
	);

	// Monitor only samples on the rising enable
	modport consumer (
		input CeR
	);

endinterface

// ==== rtl/ClockEnableGen.sv ====
`timescale 1ns/10ps

module ClockEnableGen import SaturnClockPkg::*; (
	input logic CLK,
	input logic RST_N,
	input logic CE,
	input logic Pause,
	ClockEnIf.generator Enables
);

	logic masterClk;
	logic [SlowCntWidth-1:0] slowCnt;
	logic smpcCe;
	logic masterRstN;
	logic slowWrap;

	// Master clock phase frozen while paused
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			masterClk <= 1'b0;
		end else if (CE && !Pause) begin
			masterClk <= ~masterClk;
		end
	end

	assign Enables.CeR = masterClk & ~Pause;
	assign Enables.CeF = ~masterClk & ~Pause;

	assign slowWrap = (slowCnt == SlowCntWidth'(SlowDivide - 1));

	// Divide the rising enable by seven for the system manager
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			slowCnt <= '0;
			smpcCe <= 1'b0;
		end else begin
			smpcCe <= 1'b0;
			if (Enables.CeR) begin
				if (slowWrap) begin
					slowCnt <= '0;
					smpcCe <= 1'b1;
				end else begin
					slowCnt <= slowCnt + 1'b1;
				end
			end
		end
	end

	// Release master reset once the slow enable has ticked
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			masterRstN <= 1'b0;
		end else if (smpcCe) begin
			masterRstN <= 1'b1;
		end
	end

	assign Enables.SmpcCe = smpcCe;
	assign Enables.MasterRstN = masterRstN;

	CeAlternate: assert property (
		@(posedge CLK) disable iff (!RST_N)
		Enables.CeR && CE |=> Enables.CeF || Pause
	);

	SmpcCeSingle: assert property (
		@(posedge CLK) disable iff (!RST_N)
		smpcCe |=> !smpcCe
	);

endmodule

// ==== rtl/DebugMonitor.sv ====
`timescale 1ns/10ps

module DebugMonitor import SaturnBusPkg::*, SaturnClockPkg::*; (
	input logic CLK,
	input logic RST_N,
	input logic DbgPause,
	input logic DbgBreak,
	input logic DbgRun,
	input logic Vdp1Start,
	input logic Vdp1CmdEnd,
	CpuBusIf.observer Bus,
	ClockEnIf.consumer Enables,
	output logic Pause,
	output logic [WaitCntWidth-1:0] DbgWaitCnt,
	output logic DbgHook
);

	debugState_t state;
	debugState_t nextState;
	debugState_t breakState;
	logic busActive;
	logic hookHit;

	// Where a video command event sends the latch
	assign breakState = DbgBreak ? Halted : Running;

	always_comb begin
		nextState = state;
		if (Vdp1Start) begin
			nextState = breakState;
		end else if (Vdp1CmdEnd && state != Unarmed) begin
			nextState = breakState;
		end else if (DbgRun && state == Halted) begin
			nextState = Running;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= Unarmed;
		end else begin
			state <= nextState;
		end
	end

	assign Pause = DbgPause | (state == Halted);

	// Any read or lane write counts as bus activity
	assign busActive = !Bus.RdN || !(&Bus.DqmN);
	assign hookHit = (Bus.Addr == HookAddr) && !Bus.RdN && !Bus.Cs3N;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			DbgWaitCnt <= '0;
			DbgHook <= 1'b0;
		end else if (Enables.CeR) begin
			if (busActive) begin
				DbgWaitCnt <= '0;
			end else begin
				DbgWaitCnt <= DbgWaitCnt + 1'b1;
			end
			// Sticky until reset
			if (hookHit) begin
				DbgHook <= 1'b1;
			end
		end
	end

	HaltStopsCeR: assert property (
		@(posedge CLK) disable iff (!RST_N)
		(state == Halted) |-> !Enables.CeR
	);

endmodule

// ==== rtl/SystemBusRouter.sv ====
`timescale 1ns/10ps

module SystemBusRouter import SaturnBusPkg::*; (
	CpuBusIf.observer Bus,
	input logic DramCeN,
	input logic RomCeN,
	input logic SramCeN,
	input logic SmpcCeN,
	input logic [CpuDataWidth-1:0] MemDi,
	input logic [7:0] SmpcDo,
	input logic [CpuDataWidth-1:0] ScuDo,
	input logic ScuWaitN,
	input logic MemWaitN,
	input logic BCs1N,
	input logic BCs2N,
	input logic BCsSN,
	input logic [BBusDataWidth-1:0] Vdp1Do,
	input logic [BBusDataWidth-1:0] Vdp2Do,
	input logic [BBusDataWidth-1:0] ScspDo,
	output logic [CpuDataWidth-1:0] CpuDi,
	output logic CpuWaitN,
	output logic [BBusDataWidth-1:0] BDi
);

	readSource_t source;
	logic extSel;

	// High RAM, low RAM, boot ROM or backup RAM
	assign extSel = !Bus.Cs3N || !DramCeN || !RomCeN || !SramCeN;

	always_comb begin
		if (extSel) begin
			source = ExtMemory;
		end else if (!SmpcCeN) begin
			source = SystemManager;
		end else begin
			source = BusController;
		end
	end

	always_comb begin
		case (source)
			ExtMemory: CpuDi = MemDi;
			SystemManager: CpuDi = {ByteLanes{SmpcDo}};
			default: CpuDi = ScuDo;
		endcase
	end

	// Memory wait only matters while memory is selected
	assign CpuWaitN = ScuWaitN & (MemWaitN | (source != ExtMemory));

	always_comb begin
		if (!BCs1N) begin
			BDi = Vdp1Do;
		end else if (!BCs2N) begin
			BDi = Vdp2Do;
		end else if (!BCsSN) begin
			BDi = ScspDo;
		end else begin
			BDi = '0;
		end
	end

endmodule

// ==== rtl/SaturnGlue.sv ====
`timescale 1ns/10ps

module SaturnGlue import SaturnBusPkg::*; (
	input logic CLK,
	input logic RST_N,
	input logic CE,

	input logic DbgPause,
	input logic DbgBreak,
	input logic DbgRun,
	input logic Vdp1Start,
	input logic Vdp1CmdEnd,

	input logic [CpuAddrWidth-1:0] CpuA,
	input logic CpuRdN,
	input logic [ByteLanes-1:0] CpuDqmN,
	input logic CpuCs3N,
	input logic DramCeN,
	input logic RomCeN,
	input logic SramCeN,
	input logic SmpcCeN,
	input logic [CpuDataWidth-1:0] MemDi,
	input logic [7:0] SmpcDo,
	input logic [CpuDataWidth-1:0] ScuDo,
	input logic ScuWaitN,
	input logic MemWaitN,

	input logic BCs1N,
	input logic BCs2N,
	input logic BCsSN,
	input logic [BBusDataWidth-1:0] Vdp1Do,
	input logic [BBusDataWidth-1:0] Vdp2Do,
	input logic [BBusDataWidth-1:0] ScspDo,

	output logic CeR,
	output logic CeF,
	output logic SmpcCe,
	output logic MasterRstN,
	output logic [CpuDataWidth-1:0] CpuDi,
	output logic CpuWaitN,
	output logic [BBusDataWidth-1:0] BDi,
	output logic [WaitCntWidth-1:0] DbgWaitCnt,
	output logic DbgHook
);

	logic pause;

	CpuBusIf cpuBus ();
	ClockEnIf clkEn ();

	assign cpuBus.Addr = CpuA;
	assign cpuBus.RdN = CpuRdN;
	assign cpuBus.DqmN = CpuDqmN;
	assign cpuBus.Cs3N = CpuCs3N;

	assign CeR = clkEn.CeR;
	assign CeF = clkEn.CeF;
	assign SmpcCe = clkEn.SmpcCe;
	assign MasterRstN = clkEn.MasterRstN;

	ClockEnableGen clockGen (
		.CLK(CLK),
		.RST_N(RST_N),
		.CE(CE),
		.Pause(pause),
		.Enables(clkEn)
	);

	DebugMonitor monitor (
		.CLK(CLK),
		.RST_N(RST_N),
		.DbgPause(DbgPause),
		.DbgBreak(DbgBreak),
		.DbgRun(DbgRun),
		.Vdp1Start(Vdp1Start),
		.Vdp1CmdEnd(Vdp1CmdEnd),
		.Bus(cpuBus),
		.Enables(clkEn),
		.Pause(pause),
		.DbgWaitCnt(DbgWaitCnt),
		.DbgHook(DbgHook)
	);

	SystemBusRouter router (
		.Bus(cpuBus),
		.DramCeN(DramCeN),
		.RomCeN(RomCeN),
		.SramCeN(SramCeN),
		.SmpcCeN(SmpcCeN),
		.MemDi(MemDi),
		.SmpcDo(SmpcDo),
		.ScuDo(ScuDo),
		.ScuWaitN(ScuWaitN),
		.MemWaitN(MemWaitN),
		.BCs1N(BCs1N),
		.BCs2N(BCs2N),
		.BCsSN(BCsSN),
		.Vdp1Do(Vdp1Do),
		.Vdp2Do(Vdp2Do),
		.ScspDo(ScspDo),
		.CpuDi(CpuDi),
		.CpuWaitN(CpuWaitN),
		.BDi(BDi)
	);

endmodule

// ==== test/SaturnGlueVectors.svh ====
`ifndef SATURN_GLUE_VECTORS_SVH
`define SATURN_GLUE_VECTORS_SVH

// Bus routing rows, 15 bits each
// Columns: Cs3N DramCeN RomCeN SramCeN SmpcCeN _ ScuWaitN MemWaitN _ BCs1N BCs2N BCsSN
//   _ read source (0 memory, 1 SMPC, 2 SCU) _ CpuWaitN _ B source (0 VDP1, 1 VDP2, 2 SCSP, 3 none)
localparam int RouteRows = 16;

function automatic logic [14:0] routeRow(input int index);
	case (index)
		0: return 15'b11111_11_111_10_1_11;
		1: return 15'b01111_11_011_00_1_00;
		2: return 15'b01111_10_101_00_0_01;
		3: return 15'b10111_10_110_00_0_10;
		4: return 15'b11011_11_001_00_1_00;
		5: return 15'b11101_10_100_00_0_01;
		6: return 15'b11110_11_111_01_1_11;
		// Memory wait ignored for the SMPC
		7: return 15'b11110_10_110_01_1_10;
		8: return 15'b11110_01_111_01_0_11;
		9: return 15'b11111_10_011_10_1_00;
		10: return 15'b11111_01_010_10_0_00;
		// External select beats the SMPC
		11: return 15'b01110_11_111_00_1_11;
		12: return 15'b00000_00_000_00_0_00;
		13: return 15'b10110_01_101_00_0_01;
		14: return 15'b11100_11_110_00_1_10;
		15: return 15'b11111_00_111_10_0_11;
		default: return 15'b11111_11_111_10_1_11;
	endcase
endfunction

`endif

// ==== test/SaturnGlueTb.sv ====
`timescale 1ns/10ps

module SaturnGlueTb import SaturnBusPkg::*; ();

	logic CLK, RST_N, CE;
	logic DbgPause, DbgBreak, DbgRun, Vdp1Start, Vdp1CmdEnd;
	logic [CpuAddrWidth-1:0] CpuA;
	logic CpuRdN, CpuCs3N;
	logic [ByteLanes-1:0] CpuDqmN;
	logic DramCeN, RomCeN, SramCeN, SmpcCeN, ScuWaitN, MemWaitN;
	logic [CpuDataWidth-1:0] MemDi, ScuDo;
	logic [7:0] SmpcDo;
	logic BCs1N, BCs2N, BCsSN;
	logic [BBusDataWidth-1:0] Vdp1Do, Vdp2Do, ScspDo;
	logic CeR, CeF, SmpcCe, MasterRstN, CpuWaitN, DbgHook;
	logic [CpuDataWidth-1:0] CpuDi;
	logic [BBusDataWidth-1:0] BDi;
	logic [WaitCntWidth-1:0] DbgWaitCnt;

	logic [31:0] lfsrState;
	int mismatchCount;
	int failureCount;

	`include "SaturnGlueVectors.svh"

	SaturnGlue UUT (.*);

	always #4 CLK = ~CLK;

	// Galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	task automatic takeRandom(input int bits, output logic [31:0] value);
		int i;
		value = '0;
		for (i = 0; i < bits; i++) begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
	endtask

	task automatic checkValue(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got === expected) else begin
			mismatchCount++;
			$display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	task automatic checkFreeRunning();
		int cycles;
		logic prevCeR;
		cycles = 0;
		while (!SmpcCe && cycles < 40) begin
			@(negedge CLK);
			cycles++;
		end
		if (!SmpcCe) begin
			failureCount++;
			$display("Timed out waiting for the first SmpcCe pulse");
		end
		checkValue("MasterRstN with first SmpcCe", MasterRstN, 0);
		@(negedge CLK);
		checkValue("MasterRstN after first SmpcCe", MasterRstN, 1);
		// Count cycles up to the next slow pulse
		prevCeR = CeR;
		cycles = 1;
		while (!SmpcCe && cycles < 40) begin
			@(negedge CLK);
			checkValue("CeR toggle", CeR, !prevCeR);
			checkValue("CeF against CeR", CeF, !CeR);
			prevCeR = CeR;
			cycles++;
		end
		if (!SmpcCe) begin
			failureCount++;
			$display("Timed out waiting for the second SmpcCe pulse");
		end else begin
			checkValue("SmpcCe period", cycles, 14);
		end
	endtask

	task automatic checkRouting();
		logic [14:0] row;
		logic [31:0] mem, scu, smpc, vdp1, vdp2, scsp;
		logic [31:0] expDi;
		logic [31:0] expBDi;
		int i;
		for (i = 0; i < RouteRows; i++) begin
			row = routeRow(i);
			takeRandom(32, mem);
			takeRandom(32, scu);
			takeRandom(8, smpc);
			takeRandom(16, vdp1);
			takeRandom(16, vdp2);
			takeRandom(16, scsp);
			@(posedge CLK);
			{CpuCs3N, DramCeN, RomCeN, SramCeN, SmpcCeN} <= row[14:10];
			{ScuWaitN, MemWaitN} <= row[9:8];
			{BCs1N, BCs2N, BCsSN} <= row[7:5];
			MemDi <= mem;
			ScuDo <= scu;
			SmpcDo <= smpc[7:0];
			Vdp1Do <= vdp1[15:0];
			Vdp2Do <= vdp2[15:0];
			ScspDo <= scsp[15:0];
			@(negedge CLK);
			case (row[4:3])
				2'd0: expDi = mem;
				2'd1: expDi = {4{smpc[7:0]}};
				default: expDi = scu;
			endcase
			case (row[1:0])
				2'd0: expBDi = vdp1;
				2'd1: expBDi = vdp2;
				2'd2: expBDi = scsp;
				default: expBDi = 0;
			endcase
			checkValue($sformatf("CpuDi row %0d", i), CpuDi, expDi);
			checkValue($sformatf("CpuWaitN row %0d", i), CpuWaitN, row[2]);
			checkValue($sformatf("BDi row %0d", i), BDi, expBDi);
		end
		@(posedge CLK);
		{CpuCs3N, DramCeN, RomCeN, SramCeN, SmpcCeN} <= 5'b11111;
		{BCs1N, BCs2N, BCsSN} <= 3'b111;
	endtask

	// 0 Vdp1Start, 1 Vdp1CmdEnd, 2 DbgRun
	task automatic pulseEvent(input int which);
		@(posedge CLK);
		case (which)
			0: Vdp1Start <= 1'b1;
			1: Vdp1CmdEnd <= 1'b1;
			default: DbgRun <= 1'b1;
		endcase
		@(posedge CLK);
		Vdp1Start <= 1'b0;
		Vdp1CmdEnd <= 1'b0;
		DbgRun <= 1'b0;
	endtask

	task automatic checkFrozen(input logic frozen, input string phase);
		repeat (4) begin
			@(negedge CLK);
			checkValue({phase, " CeR or CeF"}, CeR | CeF, !frozen);
			checkValue({phase, " CeR and CeF"}, CeR & CeF, 0);
		end
	endtask

	task automatic checkBreakLatch();
		@(posedge CLK);
		DbgBreak <= 1'b1;
		pulseEvent(1);
		checkFrozen(0, "Early Vdp1CmdEnd");
		pulseEvent(0);
		checkFrozen(1, "Vdp1Start break");
		pulseEvent(2);
		checkFrozen(0, "First DbgRun");
		pulseEvent(1);
		checkFrozen(1, "Vdp1CmdEnd break");
		pulseEvent(2);
		checkFrozen(0, "Second DbgRun");
		@(posedge CLK);
		DbgBreak <= 1'b0;
		DbgPause <= 1'b1;
		checkFrozen(1, "DbgPause");
		@(posedge CLK);
		DbgPause <= 1'b0;
		checkFrozen(0, "DbgPause released");
	endtask

	// Starts from a cleared counter with the bus idle
	task automatic checkCounting(input string phase, input int cycles);
		logic [WaitCntWidth-1:0] expected;
		expected = '0;
		repeat (cycles) begin
			if (CeR) begin
				expected = expected + 1'b1;
			end
			@(negedge CLK);
			checkValue(phase, DbgWaitCnt, expected);
		end
	endtask

	task automatic checkWaitCounter();
		@(posedge CLK);
		CpuRdN <= 1'b0;
		CpuDqmN <= '1;
		repeat (3) @(negedge CLK);
		checkValue("DbgWaitCnt cleared by read", DbgWaitCnt, 0);
		@(posedge CLK);
		CpuRdN <= 1'b1;
		@(negedge CLK);
		checkCounting("DbgWaitCnt idle", 12);
		@(posedge CLK);
		CpuRdN <= 1'b0;
		repeat (3) @(negedge CLK);
		checkValue("DbgWaitCnt during read", DbgWaitCnt, 0);
		@(posedge CLK);
		CpuRdN <= 1'b1;
		@(negedge CLK);
		checkCounting("DbgWaitCnt after read", 6);
		@(posedge CLK);
		CpuDqmN <= 4'b1101;
		repeat (3) @(negedge CLK);
		checkValue("DbgWaitCnt during lane write", DbgWaitCnt, 0);
		@(posedge CLK);
		CpuDqmN <= '1;
		@(negedge CLK);
		checkCounting("DbgWaitCnt after lane write", 6);
	endtask

	task automatic driveRead(input logic [CpuAddrWidth-1:0] addr, input logic cs3N);
		@(posedge CLK);
		CpuA <= addr;
		CpuRdN <= 1'b0;
		CpuCs3N <= cs3N;
		repeat (3) @(negedge CLK);
	endtask

	task automatic checkHook();
		checkValue("DbgHook before any read", DbgHook, 0);
		driveRead(HookAddr + 4, 1'b0);
		checkValue("DbgHook other address", DbgHook, 0);
		driveRead(HookAddr, 1'b1);
		checkValue("DbgHook with Cs3N high", DbgHook, 0);
		driveRead(HookAddr, 1'b0);
		checkValue("DbgHook on boot read", DbgHook, 1);
		@(posedge CLK);
		CpuA <= '0;
		CpuRdN <= 1'b1;
		CpuCs3N <= 1'b1;
		repeat (4) @(negedge CLK);
		checkValue("DbgHook held", DbgHook, 1);
	endtask

	initial begin
		CLK = 1'b0;
		RST_N = 1'b0;
		CE = 1'b1;
		{DbgPause, DbgBreak, DbgRun, Vdp1Start, Vdp1CmdEnd} = '0;
		CpuA = '0;
		CpuRdN = 1'b1;
		CpuDqmN = '1;
		CpuCs3N = 1'b1;
		{DramCeN, RomCeN, SramCeN, SmpcCeN, ScuWaitN, MemWaitN} = '1;
		MemDi = '0;
		ScuDo = '0;
		SmpcDo = '0;
		{BCs1N, BCs2N, BCsSN} = '1;
		Vdp1Do = '0;
		Vdp2Do = '0;
		ScspDo = '0;
		lfsrState = 32'hd613ba7f;
		mismatchCount = 0;
		failureCount = 0;
		repeat (2) @(posedge CLK);
		RST_N <= 1'b1;
		checkFreeRunning();
		checkRouting();
		checkBreakLatch();
		checkWaitCounter();
		checkHook();
		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
		if (mismatchCount == 0 && failureCount == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+test
rtl/SaturnBusPkg.sv
rtl/SaturnClockPkg.sv
rtl/CpuBusIf.sv
rtl/ClockEnIf.sv
rtl/ClockEnableGen.sv
rtl/DebugMonitor.sv
rtl/SystemBusRouter.sv
rtl/SaturnGlue.sv
test/SaturnGlueTb.sv

// ==== Bender.yml ====
package:
  name: saturn_glue

sources:
  - files:
      - rtl/SaturnBusPkg.sv
      - rtl/SaturnClockPkg.sv
      - rtl/CpuBusIf.sv
      - rtl/ClockEnIf.sv
      - rtl/ClockEnableGen.sv
      - rtl/DebugMonitor.sv
      - rtl/SystemBusRouter.sv
      - rtl/SaturnGlue.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/SaturnGlueTb.sv
